// File: acq_unit.f
+incdir+include
logic/acq_pkg.sv
logic/ax_if.sv
logic/dram_prefetch.sv
logic/ax_streamer.sv
logic/acq_regs.sv
logic/acq_unit.sv
tests/tb_mem_models.sv
tests/tb_acq_unit.sv

// File: Makefile
TOP := tb_acq_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f acq_unit.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "sim passed"

clean:
	rm -rf obj_dir

// File: tests/tb_acq_unit.sv
`include "acq_consts.svh"

module tb_acq_unit;
   timeunit 1ns;
   timeprecision 1ps;

   logic                     clk_i = 1'b0;
   logic                     rst_i;
   logic                     cyc_i, stb_i, we_i;
   logic [2:0]               adr_i;
   logic [`ACQ_DATA_W-1:0]   dat_i, dat_o, vx_dat_i;
   logic                     ack_o, data_ready_i, data_request_o, spi_busy_i;
   logic [`ACQ_SAMPLE_W-1:0] data_in_i;
   logic                     vx_cyc_o, vx_stb_o, vx_we_o, vx_ack_i;
   logic                     vx_available_i, vx_accessed_i;
   logic [`ACQ_ACCUM_W-1:0]  blocksize_o;
   logic                     aq_debug_mode_o, aq_enabled_o;
   logic [2:0]               aq_sample_delay_o;
   // Next unread word in the memory log
   int                       word_idx;
   // Memory request still waiting for its ready strobe
   logic                     req_open;

   acq_unit i_dut (.*);

   sample_memory i_mem (
      .clk_i, .rst_i, .data_request_i(data_request_o), .data_ready_o(data_ready_i),
      .data_o(data_in_i)
   );

   vx_slave i_vx (
      .clk_i, .vx_cyc_i(vx_cyc_o), .vx_stb_i(vx_stb_o), .vx_ack_o(vx_ack_i),
      .vx_dat_o(vx_dat_i)
   );

   always #2 clk_i = ~clk_i;

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("sim failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         stop_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // --------------------
   // Bus transfers
   // --------------------
   task automatic bus_xfer(input logic wr, input logic [2:0] addr,
                           input logic [7:0] wdata, output logic [7:0] rdata);
      int waited;
      waited = 0;
      @(posedge clk_i);
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= wr;
      adr_i <= addr;
      dat_i <= wdata;
      // Request held until acknowledged
      do begin
         @(negedge clk_i);
         waited++;
         if (waited > 40)
            stop_run($sformatf("No bus acknowledge from address %0d", addr));
      end while (!ack_o);
      rdata = dat_o;
      @(posedge clk_i);
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
   endtask

   task automatic reg_write(input logic [2:0] addr, input logic [7:0] wdata);
      logic [7:0] unused;
      bus_xfer(1'b1, addr, wdata, unused);
   endtask

   task automatic reg_read(input logic [2:0] addr, output logic [7:0] rdata);
      bus_xfer(1'b0, addr, 8'h00, rdata);
   endtask

   // Poll AQ_STATUS bit 1 before touching the stream
   task automatic wait_sample();
      logic [7:0] st;
      int polls;
      polls = 0;
      do begin
         reg_read(3'd7, st);
         polls++;
         if (polls > 50)
            stop_run("Sample-valid flag never came up");
      end while (!st[1]);
      if (i_mem.served.size() <= word_idx)
         stop_run("Sample flagged valid but memory served no new word");
   endtask

   // Three stream bytes, MSB first, with stray direct reads in between
   task automatic stream_word();
      logic [`ACQ_SAMPLE_W-1:0] w;
      logic [7:0] rd;
      int k;
      wait_sample();
      w = i_mem.served[word_idx];
      for (int b = 0; b < 3; b++) begin
         if ($urandom_range(1, 0) == 1) begin
            k = int'($urandom_range(2, 0));
            reg_read(3'(k + 1), rd);
            check("dat_o AX_DATA", 32'(rd), 32'(w[(2 - k) * 8 +: 8]));
         end
         reg_read(3'd0, rd);
         check("dat_o AX_STREAM", 32'(rd), 32'(w[(2 - b) * 8 +: 8]));
      end
      word_idx++;
   endtask

   // SPI idle for a cycle restarts the byte index
   task automatic spi_restart();
      logic [`ACQ_SAMPLE_W-1:0] w;
      logic [7:0] rd;
      wait_sample();
      w = i_mem.served[word_idx];
      reg_read(3'd0, rd);
      check("dat_o AX_STREAM", 32'(rd), 32'(w[23:16]));
      @(posedge clk_i);
      spi_busy_i <= 1'b0;
      @(posedge clk_i);
      spi_busy_i <= 1'b1;
      for (int b = 0; b < 3; b++) begin
         reg_read(3'd0, rd);
         check("dat_o AX_STREAM", 32'(rd), 32'(w[(2 - b) * 8 +: 8]));
      end
      word_idx++;
   endtask

   // Visibilities strobes follow the bus, never a write
   always @(negedge clk_i) begin
      if (!rst_i) begin
         check("vx_stb_o", 32'(vx_stb_o), 32'(stb_i && adr_i == 3'd4));
         check("vx_cyc_o", 32'(vx_cyc_o), 32'(cyc_i));
         check("vx_we_o", 32'(vx_we_o), 32'(1'b0));
      end
   end

   // Memory requests are single pulses with at most one unanswered
   always @(negedge clk_i) begin
      if (rst_i) begin
         req_open = 1'b0;
      end else begin
         if (data_request_o && req_open)
            stop_run("Memory request issued while the previous one is unanswered");
         if (data_ready_i)
            req_open = 1'b0;
         if (data_request_o)
            req_open = 1'b1;
      end
   end

   initial begin
      logic [7:0] rd;
      logic [7:0] val;
      logic [4:0] n;
      logic [1:0] flags;
      void'($urandom(32'he965_3f1a));
      rst_i          <= 1'b1;
      cyc_i          <= 1'b0;
      stb_i          <= 1'b0;
      we_i           <= 1'b0;
      adr_i          <= 3'd0;
      dat_i          <= '0;
      spi_busy_i     <= 1'b1;
      vx_available_i <= 1'b0;
      vx_accessed_i  <= 1'b0;
      word_idx = 0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;

      // --------------------
      // Reset values and control registers
      // --------------------
      reg_read(3'd6, rd);
      check("dat_o AQ_DEBUG", 32'(rd), 0);
      reg_read(3'd7, rd);
      check("dat_o AQ_STATUS", 32'(rd & 8'hfd), 0);
      check("blocksize_o", blocksize_o, 0);
      check("aq_enabled_o", 32'(aq_enabled_o), 0);
      repeat (20) begin
         val = 8'($urandom);
         reg_write(3'd6, val);
         reg_read(3'd6, rd);
         check("dat_o AQ_DEBUG", 32'(rd), 32'({val[7], 4'b0, val[2:0]}));
         check("aq_debug_mode_o", 32'(aq_debug_mode_o), 32'(val[7]));
         check("aq_sample_delay_o", 32'(aq_sample_delay_o), 32'(val[2:0]));
         val = 8'($urandom);
         reg_write(3'd7, val);
         reg_read(3'd7, rd);
         // Bit 1 belongs to the prefetcher
         check("dat_o AQ_STATUS", 32'(rd & 8'hfd), 32'(val[0]));
         check("aq_enabled_o", 32'(aq_enabled_o), 32'(val[0]));
      end

      // Block size is 2^n - 1
      repeat (20) begin
         n = 5'($urandom_range(31, 0));
         flags = 2'($urandom);
         @(posedge clk_i);
         vx_available_i <= flags[1];
         vx_accessed_i  <= flags[0];
         reg_write(3'd5, {3'($urandom), n});
         check("blocksize_o", blocksize_o, 32'((64'd1 << n) - 64'd1));
         reg_read(3'd5, rd);
         check("dat_o VX_STATUS", 32'(rd), 32'({flags, 1'b0, n}));
      end

      // --------------------
      // Antenna stream and visibilities read-back
      // --------------------
      repeat (16) stream_word();
      repeat (12) begin
         reg_read(3'd4, rd);
         check("dat_o VX_STREAM", 32'(rd), 32'(i_vx.last_dat));
      end
      repeat (4) begin
         spi_restart();
         stream_word();
      end

      $display("sim passed");
      $finish;
   end

endmodule

// File: tests/tb_mem_models.sv
`include "acq_consts.svh"

// Sample memory, answers each request after a random latency
module sample_memory (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     data_request_i,
   output logic                     data_ready_o,
   output logic [`ACQ_SAMPLE_W-1:0] data_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Words handed out, oldest first
   logic [`ACQ_SAMPLE_W-1:0] served[$];
   logic [`ACQ_SAMPLE_W-1:0] word;

   initial begin
      data_ready_o <= 1'b0;
      data_o       <= '0;
   end

   always begin
      @(negedge clk_i);
      if (!rst_i && data_request_i) begin
         // Random access latency
         repeat ($urandom_range(4, 0)) @(negedge clk_i);
         word = `ACQ_SAMPLE_W'($urandom);
         @(posedge clk_i);
         data_o       <= word;
         data_ready_o <= 1'b1;
         served.push_back(word);
         @(posedge clk_i);
         data_ready_o <= 1'b0;
      end
   end

endmodule

// Visibilities engine read-back slave
module vx_slave (
   input  logic                   clk_i,
   input  logic                   vx_cyc_i,
   input  logic                   vx_stb_i,
   output logic                   vx_ack_o,
   output logic [`ACQ_DATA_W-1:0] vx_dat_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Last byte returned
   logic [`ACQ_DATA_W-1:0] last_dat;

   initial begin
      vx_ack_o <= 1'b0;
      vx_dat_o <= '0;
      last_dat = '0;
   end

   always begin
      @(negedge clk_i);
      if (vx_cyc_i && vx_stb_i) begin
         // Stall a random number of cycles
         repeat ($urandom_range(5, 0)) @(negedge clk_i);
         last_dat = `ACQ_DATA_W'($urandom);
         @(posedge clk_i);
         vx_ack_o <= 1'b1;
         vx_dat_o <= last_dat;
         @(posedge clk_i);
         vx_ack_o <= 1'b0;
         // Master drops stb after its own ack
         for (int i = 0; i < 20 && vx_stb_i; i++)
            @(negedge clk_i);
      end
   end

endmodule

// File: logic/acq_unit.sv
`include "acq_consts.svh"

module acq_unit
   import acq_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   // Wishbone-like slave bus
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  logic [2:0]              adr_i,
   input  logic [`ACQ_DATA_W-1:0]  dat_i,
   output logic                    ack_o,
   output logic [`ACQ_DATA_W-1:0]  dat_o,
   // Sample memory port
   input  logic                    data_ready_i,
   output logic                    data_request_o,
   input  logic [`ACQ_SAMPLE_W-1:0] data_in_i,
   // SPI link status
   input  logic                    spi_busy_i,
   // Visibilities engine
   output logic                    vx_cyc_o,
   output logic                    vx_stb_o,
   output logic                    vx_we_o,
   input  logic                    vx_ack_i,
   input  logic [`ACQ_DATA_W-1:0]  vx_dat_i,
   input  logic                    vx_available_i,
   input  logic                    vx_accessed_i,
   output logic [`ACQ_ACCUM_W-1:0] blocksize_o,
   // Acquisition control
   output logic                    aq_debug_mode_o,
   output logic                    aq_enabled_o,
   output logic [2:0]              aq_sample_delay_o
);

   // Prefetcher to streamer
   sample_t fetched_data;
   logic    fetched_valid;
   logic    data_sent;

   ax_if ax ();

   dram_prefetch i_prefetch (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .data_ready_i    (data_ready_i),
      .data_in_i       (data_in_i),
      .data_request_o  (data_request_o),
      .data_sent_i     (data_sent),
      .fetched_data_o  (fetched_data),
      .fetched_valid_o (fetched_valid)
   );

   ax_streamer i_streamer (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .spi_busy_i      (spi_busy_i),
      .fetched_data_i  (fetched_data),
      .fetched_valid_i (fetched_valid),
      .data_sent_o     (data_sent),
      .ax              (ax.streamer)
   );

   acq_regs i_regs (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .cyc_i             (cyc_i),
      .stb_i             (stb_i),
      .we_i              (we_i),
      .adr_i             (acq_addr_e'(adr_i)),
      .dat_i             (dat_i),
      .ack_o             (ack_o),
      .dat_o             (dat_o),
      .ax                (ax.regs),
      .vx_cyc_o          (vx_cyc_o),
      .vx_stb_o          (vx_stb_o),
      .vx_we_o           (vx_we_o),
      .vx_ack_i          (vx_ack_i),
      .vx_dat_i          (vx_dat_i),
      .vx_available_i    (vx_available_i),
      .vx_accessed_i     (vx_accessed_i),
      .blocksize_o       (blocksize_o),
      .aq_debug_mode_o   (aq_debug_mode_o),
      .aq_enabled_o      (aq_enabled_o),
      .aq_sample_delay_o (aq_sample_delay_o)
   );

endmodule

// File: logic/acq_regs.sv
`include "acq_consts.svh"

module acq_regs
   import acq_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Wishbone-like slave bus
   input  logic                   cyc_i,
   input  logic                   stb_i,
   input  logic                   we_i,
   input  acq_addr_e              adr_i,
   input  logic [`ACQ_DATA_W-1:0] dat_i,
   output logic                   ack_o,
   output logic [`ACQ_DATA_W-1:0] dat_o,
   // Antenna data path
   ax_if.regs                     ax,
   // Visibilities read-back bus, master side
   output logic                   vx_cyc_o,
   output logic                   vx_stb_o,
   output logic                   vx_we_o,
   input  logic                   vx_ack_i,
   input  logic [`ACQ_DATA_W-1:0] vx_dat_i,
   input  logic                   vx_available_i,
   input  logic                   vx_accessed_i,
   output logic [`ACQ_ACCUM_W-1:0] blocksize_o,
   // Acquisition control
   output logic                   aq_debug_mode_o,
   output logic                   aq_enabled_o,
   output logic [2:0]             aq_sample_delay_o
);

   // First cycle of a held request only
   logic     req;
   logic     wr_en;
   // log2 of visibilities per block
   logic [4:0] log_block;
   acq_reg_u wr;
   acq_reg_u rd;

   assign req   = cyc_i && stb_i && !ack_o;
   assign wr_en = req && we_i;
   assign wr.raw = dat_i;

   // --------------------
   // Acknowledge
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i)
         ack_o <= 1'b0;
      else if (req)
         // Visibilities reads wait on the remote slave
         ack_o <= (adr_i == VX_STREAM) ? vx_ack_i : 1'b1;
      else
         ack_o <= 1'b0;
   end

   // --------------------
   // Read mux
   // --------------------
   always_comb begin
      rd.raw = '0;
      case (adr_i)
         AX_STREAM: rd.raw = ax.stream_byte;
         AX_DATA1:  rd.raw = ax.sample[`ACQ_SAMPLE_W-1 -: `ACQ_DATA_W];
         AX_DATA2:  rd.raw = ax.sample[2*`ACQ_DATA_W-1 -: `ACQ_DATA_W];
         AX_DATA3:  rd.raw = ax.sample[`ACQ_DATA_W-1:0];
         VX_STREAM: rd.raw = vx_dat_i;
         VX_STATUS: begin
            rd.vx.available = vx_available_i;
            rd.vx.accessed  = vx_accessed_i;
            rd.vx.log_block = log_block;
         end
         AQ_DEBUG: begin
            rd.dbg.mode  = aq_debug_mode_o;
            rd.dbg.delay = aq_sample_delay_o;
         end
         // Bit 1 is the read-only sample-valid flag
         AQ_STATUS: rd.raw = {{(`ACQ_DATA_W-2){1'b0}}, ax.sample_valid, aq_enabled_o};
         default:   rd.raw = '0;
      endcase
   end

   // Captured on each request cycle, last one wins for slow VX reads
   always_ff @(posedge clk_i) begin
      if (req && !we_i)
         dat_o <= rd.raw;
   end

   // --------------------
   // Write decode
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         aq_enabled_o      <= 1'b0;
         aq_debug_mode_o   <= 1'b0;
         aq_sample_delay_o <= 3'd0;
         log_block         <= 5'd0;
         blocksize_o       <= '0;
      end else if (wr_en) begin
         case (adr_i)
            VX_STATUS: begin
               log_block   <= wr.vx.log_block;
               // 2^n - 1, used as a block counter limit
               blocksize_o <= (`ACQ_ACCUM_W'(1) << wr.vx.log_block) - `ACQ_ACCUM_W'(1);
            end
            AQ_DEBUG: begin
               aq_debug_mode_o   <= wr.dbg.mode;
               aq_sample_delay_o <= wr.dbg.delay;
            end
            AQ_STATUS: aq_enabled_o <= wr.raw[0];
            default: ;
         endcase
      end
   end

   // --------------------
   // Streamer and visibilities strobes
   // --------------------
   assign ax.send  = req && !we_i && (adr_i == AX_STREAM);
   assign vx_cyc_o = cyc_i;
   assign vx_stb_o = stb_i && (adr_i == VX_STREAM);
   // Read-back only
   assign vx_we_o  = 1'b0;

   // Master drops stb after ack, so no back-to-back acks
   a_ack_single : assert property (
      @(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o
   );

endmodule

// File: logic/ax_streamer.sv
`include "acq_consts.svh"

module ax_streamer
   import acq_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,
   // Low while no SPI transfer, parks the index
   input  logic    spi_busy_i,
   input  sample_t fetched_data_i,
   input  logic    fetched_valid_i,
   output logic    data_sent_o,
   ax_if.streamer  ax
);

   // Byte index into the current sample, 0 is the MSB
   logic [1:0] index;
   logic       wrap;

   assign wrap = (index == 2'd2);

   // Prefetched sample goes straight to the register block
   assign ax.sample       = fetched_data_i;
   assign ax.sample_valid = fetched_valid_i;

   // --------------------
   // Byte select
   // --------------------
   always_comb begin
      case (index)
         2'd0:    ax.stream_byte = fetched_data_i[`ACQ_SAMPLE_W-1 -: `ACQ_DATA_W];
         2'd1:    ax.stream_byte = fetched_data_i[2*`ACQ_DATA_W-1 -: `ACQ_DATA_W];
         2'd2:    ax.stream_byte = fetched_data_i[`ACQ_DATA_W-1:0];
         default: ax.stream_byte = '0;
      endcase
   end

   // --------------------
   // Index and consumed pulse
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || !spi_busy_i)
         index <= 2'd0;
      else if (ax.send)
         index <= wrap ? 2'd0 : index + 2'd1;
   end

   // Last byte read, ask for the next sample
   always_ff @(posedge clk_i) begin
      if (rst_i)
         data_sent_o <= 1'b0;
      else
         data_sent_o <= wrap && ax.send;
   end

   a_index_in_range : assert property (
      @(posedge clk_i) disable iff (rst_i) index != 2'd3
   );

endmodule

// File: logic/dram_prefetch.sv
module dram_prefetch
   import acq_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,
   // Memory port
   input  logic    data_ready_i,
   input  sample_t data_in_i,
   output logic    data_request_o,
   // Towards the streamer
   input  logic    data_sent_i,
   output sample_t fetched_data_o,
   output logic    fetched_valid_o
);

   // Cleared by reset, kicks off the first fetch
   logic    booted;
   // One request outstanding at a time
   logic    req_pending;

   // --------------------
   // Request control
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         booted         <= 1'b0;
         data_request_o <= 1'b0;
         req_pending    <= 1'b0;
      end else begin
         booted         <= 1'b1;
         // First fetch, then a refetch per consumed sample
         data_request_o <= (!booted || data_sent_i) && !req_pending;
         if (data_ready_i)
            req_pending <= 1'b0;
         else if (data_request_o)
            req_pending <= 1'b1;
      end
   end

   // --------------------
   // Sample capture
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         fetched_valid_o <= 1'b0;
      end else if (data_ready_i) begin
         fetched_valid_o <= 1'b1;
      end else if (data_sent_i) begin
         // Sample used up, wait for the refetch
         fetched_valid_o <= 1'b0;
      end
   end

   // Payload word, no reset
   always_ff @(posedge clk_i) begin
      if (data_ready_i)
         fetched_data_o <= data_in_i;
   end

   // Memory only answers an outstanding request
   a_ready_needs_request : assert property (
      @(posedge clk_i) disable iff (rst_i) data_ready_i |-> req_pending
   );

   // Streamer only consumes a valid sample
   a_sent_needs_valid : assert property (
      @(posedge clk_i) disable iff (rst_i) data_sent_i |-> fetched_valid_o
   );

endmodule

// File: logic/ax_if.sv
`include "acq_consts.svh"

interface ax_if
   import acq_pkg::*;
();

   // Stream read accepted on the bus
   logic                   send;
   // Byte at the current stream index
   logic [`ACQ_DATA_W-1:0] stream_byte;
   // Sample held by the prefetcher
   sample_t                sample;
   logic                   sample_valid;

   modport regs (output send, input stream_byte, input sample, input sample_valid);

   modport streamer (input send, output stream_byte, output sample, output sample_valid);

endinterface

// File: logic/acq_pkg.sv
`include "acq_consts.svh"

package acq_pkg;

   // Register map of the acquisition unit
   typedef enum logic [2:0] {
      AX_STREAM = 3'd0,
      AX_DATA1  = 3'd1,
      AX_DATA2  = 3'd2,
      AX_DATA3  = 3'd3,
      VX_STREAM = 3'd4,
      VX_STATUS = 3'd5,
      AQ_DEBUG  = 3'd6,
      AQ_STATUS = 3'd7
   } acq_addr_e;

   // AQ_DEBUG layout
   typedef struct packed {
      logic       mode;
      logic [3:0] pad;
      logic [2:0] delay;
   } aq_debug_t;

   // VX_STATUS layout, log2 of block size in low bits
   typedef struct packed {
      logic       available;
      logic       accessed;
      logic       pad;
      logic [4:0] log_block;
   } vx_status_t;

   // One bus byte, seen raw or through a register view
   typedef union packed {
      logic [`ACQ_DATA_W-1:0] raw;
      aq_debug_t              dbg;
      vx_status_t             vx;
   } acq_reg_u;

   // Antenna sample word
   typedef logic [`ACQ_SAMPLE_W-1:0] sample_t;

endpackage

// File: include/acq_consts.svh
`ifndef ACQ_CONSTS_SVH
`define ACQ_CONSTS_SVH

// --------------------
// Bus and datapath widths
// --------------------

// Wishbone-like slave bus data width
`define ACQ_DATA_W 8

// One antenna sample as fetched from memory
// Three bus bytes per sample
`define ACQ_SAMPLE_W 24

// Width of the visibilities accumulators
// Also the width of the block-size output
`define ACQ_ACCUM_W 32

`endif
